//--- Bender.yml
package:
  name: fetch_top

sources:
  - design/isa_pkg.sv
  - design/fetch_bus_pkg.sv
  - design/fetch_cfg.sv
  - design/pc_gen.sv
  - design/imem_port.sv
  - design/if_stage.sv
  - design/fetch_top.sv
  - target: test
    files:
      - bench/fetch_checker.sv
      - bench/tb_fetch_top.sv

//--- bench/fetch_checker.sv
// Reference model of the fetch stream; assumes a single enable and at most one read in flight
// Memory rule is data = address ^ 0x5A5A_0000, faults where address bits 7:4 are all ones
`timescale 1ns/10ps
`default_nettype none

module fetch_checker #(
	parameter logic [isa_pkg::WORD_W-1:0] RESET_VECTOR = 32'h0000_0100
) (
	input wire                                   clk,
	input wire                                   reset_i,
	input wire                                   cfg_req_i,
	input wire                                   cfg_we_i,
	input wire  [fetch_bus_pkg::CFG_ADDR_W-1:0]  cfg_addr_i,
	input wire  [isa_pkg::WORD_W-1:0]            cfg_wdata_i,
	input wire                                   cfg_ack_i,
	input wire  [isa_pkg::WORD_W-1:0]            cfg_rdata_i,
	input wire                                   freeze_i,
	input wire                                   flush_i,
	input wire  [isa_pkg::WORD_W-1:0]            target_i,
	input wire  [isa_pkg::WORD_W-1:0]            insn_i,
	input wire  [isa_pkg::WORD_W-1:0]            pc_i,
	input fetch_bus_pkg::fetch_fault_t           fault_i,
	input wire                                   insn_valid_i
);

	string                       test_name = "reset";
	int                          error_count;
	int                          taken_count;
	int                          fault_count;
	int                          test_count;
	int                          errors_at_start;
	int                          words_at_start;
	int                          faults_at_start;
	logic [isa_pkg::WORD_W-1:0]  exp_pc;
	logic [isa_pkg::WORD_W-1:0]  boot_model;
	logic [isa_pkg::WORD_W-1:0]  fault_model;
	logic [isa_pkg::WORD_W-1:0]  read_exp;
	logic [isa_pkg::WORD_W-1:0]  hold_insn;
	logic [isa_pkg::WORD_W-1:0]  hold_pc;
	fetch_bus_pkg::fetch_fault_t hold_fault;
	fetch_bus_pkg::fetch_fault_t exp_fault;
	logic                        en_model;
	logic                        booted;
	logic                        hold_pending;
	logic                        read_pending;

	////////////////////////////////////////////////////////////////////////////
	// Memory rule
	////////////////////////////////////////////////////////////////////////////

	function automatic fetch_bus_pkg::fetch_fault_t fault_for(input logic [31:0] addr);
		fetch_bus_pkg::fetch_fault_t f;
		f = '0;
		if (addr[7:4] == 4'hf) begin
			case (addr[3:2])
				2'd1:    f.tlb_miss = 1'b1;
				2'd2:    f.mmu_fault = 1'b1;
				default: f.bus_err = 1'b1;
			endcase
		end
		return f;
	endfunction

	// Faulted words arrive as the idle NOP
	function automatic logic [31:0] insn_for(input logic [31:0] addr);
		return (addr[7:4] == 4'hf) ? isa_pkg::NOP_IDLE : (addr ^ 32'h5A5A_0000);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("CHECK FAILED %s: %s expected %h, actual %h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic report_problem(input string what);
		error_count++;
		$display("Test %s: %s", test_name, what);
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = error_count;
		words_at_start  = taken_count;
		faults_at_start = fault_count;
	endtask

	function automatic int faults_in_test();
		return fault_count - faults_at_start;
	endfunction

	task automatic end_test();
		int errs;
		errs = error_count - errors_at_start;
		test_count++;
		$display("%s %s: %0d words taken, %0d faulted, %0d errors", (errs == 0) ? "PASS" : "FAIL",
			test_name, taken_count - words_at_start, faults_in_test(), errs);
	endtask

	task automatic print_summary();
		$display("Summary: %0d tests, %0d words taken, %0d faulted, %0d errors",
			test_count, taken_count, fault_count, error_count);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Model, updated once per rising edge
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset_i) begin
			exp_pc       = '0;
			boot_model   = RESET_VECTOR;
			fault_model  = '0;
			en_model     = 1'b0;
			booted       = 1'b0;
			hold_pending = 1'b0;
			read_pending = 1'b0;
		end else begin
			// Read data comes back with ack
			if (read_pending && cfg_ack_i) begin
				check_value("config read", read_exp, cfg_rdata_i);
				read_pending = 1'b0;
			end
			if (!booted && insn_valid_i)
				report_problem("a word was delivered before fetch was enabled");
			// Frozen word must stay put
			if (hold_pending && !flush_i) begin
				if (!insn_valid_i)
					report_problem("the held word vanished while decode was frozen");
				check_value("held insn", hold_insn, insn_i);
				check_value("held pc", hold_pc, pc_i);
				check_value("held fault", {29'd0, hold_fault}, {29'd0, fault_i});
			end
			hold_pending = insn_valid_i && freeze_i;
			hold_insn    = insn_i;
			hold_pc      = pc_i;
			hold_fault   = fault_i;
			// Read snapshot, before this edge's updates
			if (cfg_req_i && !cfg_ack_i && !cfg_we_i) begin
				read_pending = 1'b1;
				case (cfg_addr_i)
					fetch_bus_pkg::CFG_BOOT:   read_exp = boot_model;
					fetch_bus_pkg::CFG_CTRL:   read_exp = {31'd0, en_model};
					fetch_bus_pkg::CFG_FAULTS: read_exp = fault_model;
					default:                   read_exp = '0;
				endcase
			end
			// Word taken by decode
			if (insn_valid_i && !freeze_i) begin
				exp_fault = fault_for(exp_pc);
				check_value("pc", exp_pc, pc_i);
				check_value("insn", insn_for(exp_pc), insn_i);
				check_value("fault", {29'd0, exp_fault}, {29'd0, fault_i});
				if (exp_fault != '0) begin
					fault_model++;
					fault_count++;
				end
				taken_count++;
				exp_pc = exp_pc + 32'd4;
			end
			if (flush_i)
				exp_pc = {target_i[31:2], 2'b00};
			// Config writes land last
			if (cfg_req_i && !cfg_ack_i && cfg_we_i) begin
				case (cfg_addr_i)
					fetch_bus_pkg::CFG_BOOT:   boot_model = cfg_wdata_i;
					fetch_bus_pkg::CFG_FAULTS: fault_model = '0;
					fetch_bus_pkg::CFG_CTRL: begin
						// Enable edge restarts at the boot vector
						if (cfg_wdata_i[0] && !en_model) begin
							exp_pc = {boot_model[31:2], 2'b00};
							booted = 1'b1;
						end
						en_model = cfg_wdata_i[0];
					end
					default: ;
				endcase
			end
		end
	end

endmodule : fetch_checker

`default_nettype wire

//--- bench/tb_fetch_top.sv
// Testbench for fetch_top with seeded random memory latency, freeze and flush
// Memory model answers one four-phase transfer at a time with 0 to 5 cycles of latency
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_top;

	localparam logic [31:0] RESET_VECTOR   = 32'h0000_0100;
	localparam int          NUM_TESTS      = 6;
	localparam int          TIMEOUT_CYCLES = NUM_TESTS * 400 * 12;
	localparam int          STREAM_WORDS   = 150;

	logic                        clk;
	logic                        reset_i;
	logic                        imem_req_o;
	logic [31:0]                 imem_addr_o;
	logic                        imem_ack_i;
	logic [31:0]                 imem_rdata_i;
	logic                        imem_err_i;
	logic [isa_pkg::TAG_W-1:0]   imem_tag_i;
	logic                        cfg_req_i;
	logic                        cfg_we_i;
	logic [1:0]                  cfg_addr_i;
	logic [31:0]                 cfg_wdata_i;
	logic                        cfg_ack_o;
	logic [31:0]                 cfg_rdata_o;
	logic                        freeze_i;
	logic                        flush_i;
	logic [31:0]                 target_i;
	logic [31:0]                 insn_o;
	logic [31:0]                 pc_o;
	fetch_bus_pkg::fetch_fault_t fault_o;
	logic                        insn_valid_o;

	integer      seed = 32'h4469_6ea3;
	logic        freeze_mode;
	logic        flush_mode;
	logic        fault_mode;
	logic        mem_busy;
	int          mem_delay;
	int          cycles;
	logic        req_seen;
	logic [31:0] addr_seen;
	logic [31:0] boot_vec;
	logic [31:0] rdata;

	fetch_top #(.RESET_VECTOR(RESET_VECTOR)) fetch_top_inst (.*);

	fetch_checker #(.RESET_VECTOR(RESET_VECTOR)) fetch_checker_inst (
		.clk, .reset_i,
		.cfg_req_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
		.cfg_ack_i (cfg_ack_o), .cfg_rdata_i (cfg_rdata_o),
		.freeze_i, .flush_i, .target_i,
		.insn_i (insn_o), .pc_i (pc_o), .fault_i (fault_o), .insn_valid_i (insn_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory responder and core-side stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_memory();
		if (imem_ack_i) begin
			// Fourth phase
			if (!req_seen)
				imem_ack_i = 1'b0;
		end else if (req_seen) begin
			if (!mem_busy) begin
				mem_busy  = 1'b1;
				mem_delay = {$random(seed)} % 6;
			end
			if (mem_delay == 0) begin
				mem_busy     = 1'b0;
				imem_ack_i   = 1'b1;
				imem_rdata_i = addr_seen ^ 32'h5A5A_0000;
				imem_err_i   = (addr_seen[7:4] == 4'hf);
				case (addr_seen[3:2])
					2'd1:    imem_tag_i = isa_pkg::TAG_TLB_MISS;
					2'd2:    imem_tag_i = isa_pkg::TAG_MMU_FAULT;
					default: imem_tag_i = isa_pkg::TAG_BUS_ERR;
				endcase
				if (!imem_err_i)
					imem_tag_i = '0;
			end else begin
				mem_delay--;
			end
		end
	endtask

	initial begin
		mem_busy  = 1'b0;
		mem_delay = 0;
		@(negedge reset_i);
		forever begin
			@(posedge clk);
			req_seen  = imem_req_o;
			addr_seen = imem_addr_o;
			#2;
			drive_memory();
			freeze_i = freeze_mode && (({$random(seed)} % 3) == 0);
			flush_i  = flush_mode && (({$random(seed)} % 16) == 0);
			// Fault runs aim the redirect at the xF0 block
			if (fault_mode)
				target_i = ({$random(seed)} & 32'h0000_3f0f) | 32'h0000_00f0;
			else
				target_i = {$random(seed)} & 32'h0000_3fff;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Host tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic cfg_access(input logic we, input logic [1:0] addr, input logic [31:0] wdata,
		output logic [31:0] data);
		@(posedge clk);
		#2;
		cfg_req_i   = 1'b1;
		cfg_we_i    = we;
		cfg_addr_i  = addr;
		cfg_wdata_i = wdata;
		do @(posedge clk); while (!cfg_ack_o);
		data = cfg_rdata_o;
		#2;
		cfg_req_i = 1'b0;
		do @(posedge clk); while (cfg_ack_o);
	endtask

	task automatic wait_words(input int n);
		int target;
		target = fetch_checker_inst.taken_count + n;
		do begin
			@(posedge clk);
			#1;
		end while (fetch_checker_inst.taken_count < target);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset_i      = 1'b1;
		imem_ack_i   = 1'b0;
		imem_rdata_i = '0;
		imem_err_i   = 1'b0;
		imem_tag_i   = '0;
		cfg_req_i    = 1'b0;
		cfg_we_i     = 1'b0;
		cfg_addr_i   = '0;
		cfg_wdata_i  = '0;
		freeze_i     = 1'b0;
		flush_i      = 1'b0;
		target_i     = '0;
		freeze_mode  = 1'b0;
		flush_mode   = 1'b0;
		fault_mode   = 1'b0;
		boot_vec     = {$random(seed)} & 32'h0000_3ffc;
		repeat (8) @(posedge clk);
		#2;
		reset_i = 1'b0;

		fetch_checker_inst.start_test("boot");
		cfg_access(1'b1, fetch_bus_pkg::CFG_BOOT, boot_vec, rdata);
		cfg_access(1'b0, fetch_bus_pkg::CFG_BOOT, '0, rdata);
		// Quiet window, fetch still disabled
		repeat (20) @(posedge clk);
		cfg_access(1'b1, fetch_bus_pkg::CFG_CTRL, 32'd1, rdata);
		wait_words(8);
		fetch_checker_inst.end_test();

		fetch_checker_inst.start_test("sequential");
		wait_words(STREAM_WORDS);
		fetch_checker_inst.end_test();

		fetch_checker_inst.start_test("freeze");
		freeze_mode = 1'b1;
		wait_words(STREAM_WORDS);
		fetch_checker_inst.end_test();

		fetch_checker_inst.start_test("flush");
		flush_mode = 1'b1;
		wait_words(STREAM_WORDS);
		fetch_checker_inst.end_test();

		fetch_checker_inst.start_test("faults");
		fault_mode = 1'b1;
		wait_words(STREAM_WORDS);
		if (fetch_checker_inst.faults_in_test() == 0)
			fetch_checker_inst.report_problem("no faulted word was taken during the fault test");
		fetch_checker_inst.end_test();

		fetch_checker_inst.start_test("fault counter");
		freeze_mode = 1'b0;
		flush_mode  = 1'b0;
		fault_mode  = 1'b0;
		cfg_access(1'b0, fetch_bus_pkg::CFG_FAULTS, '0, rdata);
		cfg_access(1'b1, fetch_bus_pkg::CFG_CTRL, 32'd0, rdata);
		// Let the last fetch finish
		do begin
			@(posedge clk);
			#1;
		end while (imem_req_o || imem_ack_i || insn_valid_o);
		cfg_access(1'b0, fetch_bus_pkg::CFG_FAULTS, '0, rdata);
		cfg_access(1'b1, fetch_bus_pkg::CFG_FAULTS, '0, rdata);
		cfg_access(1'b0, fetch_bus_pkg::CFG_FAULTS, '0, rdata);
		fetch_checker_inst.check_value("fault counter after clear", 32'd0, rdata);
		fetch_checker_inst.end_test();

		fetch_checker_inst.print_summary();
		if (fetch_checker_inst.error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Tests times 400 words times 12 cycles
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule : tb_fetch_top

`default_nettype wire

//--- design/fetch_bus_pkg.sv
// Structures passed between the fetch blocks, plus the config register map
// Widths are taken from isa_pkg
`default_nettype none

package fetch_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Fetch path records
	////////////////////////////////////////////////////////////////////////////

	// Request from the PC generator, pc is word aligned
	typedef struct packed {
		logic [isa_pkg::WORD_W-1:0] pc;
		logic                       epoch;
	} fetch_req_t;

	// One-cycle response from the bus port
	typedef struct packed {
		logic                       valid;
		logic [isa_pkg::WORD_W-1:0] data;
		logic                       err;
		logic [isa_pkg::TAG_W-1:0]  tag;
		logic [isa_pkg::WORD_W-1:0] pc;
		logic                       epoch;
	} fetch_rsp_t;

	// Decoded fault flags, at most one high
	typedef struct packed {
		logic tlb_miss;
		logic mmu_fault;
		logic bus_err;
	} fetch_fault_t;

	////////////////////////////////////////////////////////////////////////////
	// Config register map
	////////////////////////////////////////////////////////////////////////////

	localparam int CFG_ADDR_W = 2;

	localparam logic [CFG_ADDR_W-1:0] CFG_BOOT   = 2'd0;
	localparam logic [CFG_ADDR_W-1:0] CFG_CTRL   = 2'd1;
	localparam logic [CFG_ADDR_W-1:0] CFG_FAULTS = 2'd2;

endpackage : fetch_bus_pkg

`default_nettype wire

//--- design/fetch_cfg.sv
// Host must keep req high until ack and drop it before the next access
// Fault counter saturates; a write to CFG_FAULTS clears it
`timescale 1ns/10ps
`default_nettype none

module fetch_cfg #(
	parameter logic [isa_pkg::WORD_W-1:0] RESET_VECTOR = '0
) (
	input  wire                                   clk,
	input  wire                                   reset_i,
	input  wire                                   cfg_req_i,
	input  wire                                   cfg_we_i,
	input  wire  [fetch_bus_pkg::CFG_ADDR_W-1:0]  cfg_addr_i,
	input  wire  [isa_pkg::WORD_W-1:0]            cfg_wdata_i,
	output logic                                  cfg_ack_o,
	output logic [isa_pkg::WORD_W-1:0]            cfg_rdata_o,
	input  wire                                   fault_seen_i,
	output logic [isa_pkg::WORD_W-1:0]            boot_vec_o,
	output logic                                  fetch_en_o
);

	logic [isa_pkg::WORD_W-1:0] fault_cnt_q;
	logic                       access;

	// New access only on the first cycle req is seen
	assign access = cfg_req_i & ~cfg_ack_o;

	// Ack follows req by one cycle in both directions
	always_ff @(posedge clk) begin
		if (reset_i) begin
			cfg_ack_o   <= 1'b0;
			boot_vec_o  <= RESET_VECTOR;
			fetch_en_o  <= 1'b0;
			fault_cnt_q <= '0;
		end else begin
			cfg_ack_o <= cfg_req_i;
			if (access && cfg_we_i && cfg_addr_i == fetch_bus_pkg::CFG_BOOT)
				boot_vec_o <= cfg_wdata_i;
			if (access && cfg_we_i && cfg_addr_i == fetch_bus_pkg::CFG_CTRL)
				fetch_en_o <= cfg_wdata_i[0];
			// Clear beats a same-cycle fault
			if (access && cfg_we_i && cfg_addr_i == fetch_bus_pkg::CFG_FAULTS)
				fault_cnt_q <= '0;
			else if (fault_seen_i && fault_cnt_q != '1)
				fault_cnt_q <= fault_cnt_q + 1'b1;
		end
	end

	// Read data captured with the access
	always_ff @(posedge clk) begin
		if (access) begin
			case (cfg_addr_i)
				fetch_bus_pkg::CFG_BOOT:   cfg_rdata_o <= boot_vec_o;
				fetch_bus_pkg::CFG_CTRL:   cfg_rdata_o <= {{(isa_pkg::WORD_W-1){1'b0}}, fetch_en_o};
				fetch_bus_pkg::CFG_FAULTS: cfg_rdata_o <= fault_cnt_q;
				default:                   cfg_rdata_o <= '0;
			endcase
		end
	end

	// Host still holds req when ack comes up
	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
		$rose(cfg_ack_o) |-> cfg_req_i);

endmodule : fetch_cfg

`default_nettype wire

//--- design/fetch_top.sv
// Fetch subsystem top; the instruction bus allows one outstanding four-phase transfer
// RESET_VECTOR sets the boot register value after reset
`timescale 1ns/10ps
`default_nettype none

module fetch_top #(
	parameter logic [isa_pkg::WORD_W-1:0] RESET_VECTOR = 32'h0000_0100
) (
	input  wire                                   clk,
	input  wire                                   reset_i,
	// Instruction memory bus
	output logic                                  imem_req_o,
	output logic [isa_pkg::WORD_W-1:0]            imem_addr_o,
	input  wire                                   imem_ack_i,
	input  wire  [isa_pkg::WORD_W-1:0]            imem_rdata_i,
	input  wire                                   imem_err_i,
	input  wire  [isa_pkg::TAG_W-1:0]             imem_tag_i,
	// Config port
	input  wire                                   cfg_req_i,
	input  wire                                   cfg_we_i,
	input  wire  [fetch_bus_pkg::CFG_ADDR_W-1:0]  cfg_addr_i,
	input  wire  [isa_pkg::WORD_W-1:0]            cfg_wdata_i,
	output logic                                  cfg_ack_o,
	output logic [isa_pkg::WORD_W-1:0]            cfg_rdata_o,
	// Core side
	input  wire                                   freeze_i,
	input  wire                                   flush_i,
	input  wire  [isa_pkg::WORD_W-1:0]            target_i,
	output logic [isa_pkg::WORD_W-1:0]            insn_o,
	output logic [isa_pkg::WORD_W-1:0]            pc_o,
	output fetch_bus_pkg::fetch_fault_t           fault_o,
	output logic                                  insn_valid_o
);

	logic [isa_pkg::WORD_W-1:0] boot_vec;
	logic                       fetch_en;
	logic                       fault_seen;
	logic                       issue;
	logic                       port_idle;
	logic                       slot_free;
	logic                       epoch;
	fetch_bus_pkg::fetch_req_t  fetch_req;
	fetch_bus_pkg::fetch_rsp_t  fetch_rsp;

	fetch_cfg #(
		.RESET_VECTOR (RESET_VECTOR)
	) fetch_cfg_inst (
		.clk, .reset_i,
		.cfg_req_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_ack_o, .cfg_rdata_o,
		.fault_seen_i (fault_seen),
		.boot_vec_o   (boot_vec),
		.fetch_en_o   (fetch_en)
	);

	pc_gen pc_gen_inst (
		.clk, .reset_i,
		.boot_vec_i (boot_vec), .fetch_en_i (fetch_en),
		.flush_i, .target_i,
		.port_idle_i (port_idle), .slot_free_i (slot_free),
		.issue_o (issue), .req_o (fetch_req), .epoch_o (epoch)
	);

	imem_port imem_port_inst (
		.clk, .reset_i,
		.issue_i (issue), .req_i (fetch_req), .idle_o (port_idle),
		.imem_req_o, .imem_addr_o, .imem_ack_i, .imem_rdata_i, .imem_err_i, .imem_tag_i,
		.rsp_o (fetch_rsp)
	);

	if_stage if_stage_inst (
		.clk, .reset_i,
		.rsp_i (fetch_rsp), .epoch_i (epoch),
		.freeze_i, .flush_i,
		.insn_o, .pc_o, .fault_o, .insn_valid_o,
		.slot_free_o (slot_free), .fault_seen_o (fault_seen)
	);

endmodule : fetch_top

`default_nettype wire

//--- design/if_stage.sv
// Holds at most one word under freeze; the PC generator must not issue while it is held
// Responses from a stale epoch or in a flush cycle are dropped
`timescale 1ns/10ps
`default_nettype none

module if_stage (
	input  wire                              clk,
	input  wire                              reset_i,
	input  fetch_bus_pkg::fetch_rsp_t        rsp_i,
	input  wire                              epoch_i,
	input  wire                              freeze_i,
	input  wire                              flush_i,
	output logic [isa_pkg::WORD_W-1:0]       insn_o,
	output logic [isa_pkg::WORD_W-1:0]       pc_o,
	output fetch_bus_pkg::fetch_fault_t      fault_o,
	output logic                             insn_valid_o,
	output logic                             slot_free_o,
	output logic                             fault_seen_o
);

	logic                        live;
	logic                        save;
	logic                        saved_q;
	logic [isa_pkg::WORD_W-1:0]  live_insn;
	logic [isa_pkg::WORD_W-1:0]  insn_saved_q;
	logic [isa_pkg::WORD_W-1:0]  pc_saved_q;
	fetch_bus_pkg::fetch_fault_t live_fault;
	fetch_bus_pkg::fetch_fault_t fault_saved_q;
	fetch_bus_pkg::fetch_fault_t sel_fault;

	////////////////////////////////////////////////////////////////////////////
	// Incoming response
	////////////////////////////////////////////////////////////////////////////

	// Current-path response only
	assign live = rsp_i.valid & (rsp_i.epoch == epoch_i) & ~flush_i;

	// Fault flags from the bus tag
	assign live_fault = '{
		tlb_miss:  rsp_i.err & (rsp_i.tag == isa_pkg::TAG_TLB_MISS),
		mmu_fault: rsp_i.err & (rsp_i.tag == isa_pkg::TAG_MMU_FAULT),
		bus_err:   rsp_i.err & (rsp_i.tag == isa_pkg::TAG_BUS_ERR)
	};

	// Faulted word never reaches decode as data
	assign live_insn = rsp_i.err ? isa_pkg::NOP_IDLE : rsp_i.data;

	// Capture when decode is frozen
	assign save = live & freeze_i & ~saved_q;

	////////////////////////////////////////////////////////////////////////////
	// Save register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i)
			saved_q <= 1'b0;
		else if (flush_i)
			saved_q <= 1'b0;
		else if (save)
			saved_q <= 1'b1;
		else if (!freeze_i)
			saved_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (save) begin
			insn_saved_q  <= live_insn;
			pc_saved_q    <= rsp_i.pc;
			fault_saved_q <= live_fault;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode side
	////////////////////////////////////////////////////////////////////////////

	assign insn_valid_o = ~flush_i & (saved_q | live);
	assign insn_o       = saved_q ? insn_saved_q : live_insn;
	assign pc_o         = saved_q ? pc_saved_q : rsp_i.pc;
	assign sel_fault    = saved_q ? fault_saved_q : live_fault;

	// Flags only beside a valid word
	assign fault_o = insn_valid_o ? sel_fault : '0;

	// One pulse per faulted word actually taken
	assign fault_seen_o = insn_valid_o & ~freeze_i & (|fault_o);

	// Nothing pending and nothing held
	assign slot_free_o = ~saved_q & ~rsp_i.valid;

	// Held word stays put until freeze falls or a flush drops it
	a_hold_stable: assert property (@(posedge clk) disable iff (reset_i)
		insn_valid_o && freeze_i |=> flush_i || (insn_valid_o && $stable(insn_o)
			&& $stable(pc_o) && $stable(fault_o)));

	// Every bus error maps to exactly one flag
	a_fault_onehot: assert property (@(posedge clk) disable iff (reset_i)
		rsp_i.valid && rsp_i.err |-> $onehot(live_fault));

	// Old path is gone by the cycle after a flush
	a_flush_quiet: assert property (@(posedge clk) disable iff (reset_i)
		flush_i |=> !insn_valid_o);

endmodule : if_stage

`default_nettype wire

//--- design/imem_port.sv
// Four-phase master, one transfer at a time; memory must hold ack until req falls
// Response is a one-cycle pulse one cycle after ack is sampled high
`timescale 1ns/10ps
`default_nettype none

module imem_port (
	input  wire                              clk,
	input  wire                              reset_i,
	input  wire                              issue_i,
	input  fetch_bus_pkg::fetch_req_t        req_i,
	output logic                             idle_o,
	output logic                             imem_req_o,
	output logic [isa_pkg::WORD_W-1:0]       imem_addr_o,
	input  wire                              imem_ack_i,
	input  wire  [isa_pkg::WORD_W-1:0]       imem_rdata_i,
	input  wire                              imem_err_i,
	input  wire  [isa_pkg::TAG_W-1:0]        imem_tag_i,
	output fetch_bus_pkg::fetch_rsp_t        rsp_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_ACK_LOW
	} state_e;

	state_e                     state_q;
	fetch_bus_pkg::fetch_req_t  req_q;
	logic                       rsp_valid_q;
	logic [isa_pkg::WORD_W-1:0] rdata_q;
	logic                       err_q;
	logic [isa_pkg::TAG_W-1:0]  tag_q;
	logic                       start;
	logic                       capture;

	// Free once ack has fallen, so back-to-back starts are possible
	assign idle_o  = (state_q == ST_IDLE) | ((state_q == ST_ACK_LOW) & ~imem_ack_i);
	assign start   = issue_i & idle_o;
	assign capture = (state_q == ST_REQ) & imem_ack_i;

	////////////////////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q     <= ST_IDLE;
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= capture;
			case (state_q)
				ST_IDLE:    if (start) state_q <= ST_REQ;
				ST_REQ:     if (imem_ack_i) state_q <= ST_ACK_LOW;
				// Wait for the fourth phase
				ST_ACK_LOW: if (!imem_ack_i) state_q <= start ? ST_REQ : ST_IDLE;
				default:    state_q <= ST_IDLE;
			endcase
		end
	end

	// Request record and read data
	always_ff @(posedge clk) begin
		if (start)
			req_q <= req_i;
		if (capture) begin
			rdata_q <= imem_rdata_i;
			err_q   <= imem_err_i;
			tag_q   <= imem_tag_i;
		end
	end

	assign imem_req_o  = (state_q == ST_REQ);
	assign imem_addr_o = req_q.pc;

	// Response tagged with the pc and epoch it was issued under
	assign rsp_o = '{valid: rsp_valid_q, data: rdata_q, err: err_q, tag: tag_q,
		pc: req_q.pc, epoch: req_q.epoch};

	// Address held for the whole request phase
	a_addr_stable: assert property (@(posedge clk) disable iff (reset_i)
		imem_req_o && $past(imem_req_o) |-> $stable(imem_addr_o));

	// No new request while memory still acks the last one
	a_no_req_in_ack: assert property (@(posedge clk) disable iff (reset_i)
		$rose(imem_req_o) |-> !$past(imem_ack_i));

endmodule : imem_port

`default_nettype wire

//--- design/isa_pkg.sv
// ISA constants shared by the fetch path; only the fixed 32-bit word format is supported
// Tag codes follow the instruction bus convention for fault reporting
`default_nettype none

package isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Word format
	////////////////////////////////////////////////////////////////////////////

	// Instruction and address width
	localparam int WORD_W = 32;

	// Major opcode field
	localparam int OPC_W = 6;

	// NOP major opcode
	localparam logic [OPC_W-1:0] OPC_NOP = 6'b000101;

	// Idle NOP, issued in place of a discarded or faulted fetch
	localparam logic [WORD_W-1:0] NOP_IDLE = {OPC_NOP, 26'h041_0000};

	////////////////////////////////////////////////////////////////////////////
	// Instruction bus tags
	////////////////////////////////////////////////////////////////////////////

	// Width of the bus tag
	localparam int TAG_W = 4;

	// Translation miss in the ITLB
	localparam logic [TAG_W-1:0] TAG_TLB_MISS = 4'hd;

	// Page protection fault from the IMMU
	localparam logic [TAG_W-1:0] TAG_MMU_FAULT = 4'hc;

	// Plain bus error
	localparam logic [TAG_W-1:0] TAG_BUS_ERR = 4'hb;

endpackage : isa_pkg

`default_nettype wire

//--- design/pc_gen.sv
// One fetch in flight at most; issue waits for an idle port and a free fetch slot
// Boot vector and flush target are forced to word alignment
`timescale 1ns/10ps
`default_nettype none

module pc_gen (
	input  wire                              clk,
	input  wire                              reset_i,
	input  wire  [isa_pkg::WORD_W-1:0]       boot_vec_i,
	input  wire                              fetch_en_i,
	input  wire                              flush_i,
	input  wire  [isa_pkg::WORD_W-1:0]       target_i,
	input  wire                              port_idle_i,
	input  wire                              slot_free_i,
	output logic                             issue_o,
	output fetch_bus_pkg::fetch_req_t        req_o,
	output logic                             epoch_o
);

	logic [isa_pkg::WORD_W-1:0] pc_q;
	logic                       en_d_q;
	logic                       en_rise;
	logic                       used_q;

	////////////////////////////////////////////////////////////////////////////
	// Issue decision
	////////////////////////////////////////////////////////////////////////////

	// Enable edge, boot vector goes in this cycle
	assign en_rise = fetch_en_i & ~en_d_q;

	// No issue while the PC is being reloaded
	assign issue_o = fetch_en_i & ~en_rise & ~flush_i & port_idle_i & slot_free_i;

	assign req_o   = '{pc: pc_q, epoch: epoch_o};

	////////////////////////////////////////////////////////////////////////////
	// PC and epoch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q    <= '0;
			epoch_o <= 1'b0;
			en_d_q  <= 1'b0;
			used_q  <= 1'b0;
		end else begin
			en_d_q <= fetch_en_i;
			// Flush redirects the PC
			// Epoch moves only if a fetch went out under it, so an older stale fetch never matches
			if (flush_i) begin
				pc_q    <= {target_i[isa_pkg::WORD_W-1:2], 2'b00};
				epoch_o <= epoch_o ^ used_q;
				used_q  <= 1'b0;
			end else if (en_rise) begin
				pc_q <= {boot_vec_i[isa_pkg::WORD_W-1:2], 2'b00};
			end else if (issue_o) begin
				pc_q   <= pc_q + 'd4;
				used_q <= 1'b1;
			end
		end
	end

	// Issue only to an idle port, which is busy the cycle after
	a_issue_idle: assert property (@(posedge clk) disable iff (reset_i)
		issue_o |-> port_idle_i ##1 !port_idle_i);

endmodule : pc_gen

`default_nettype wire

//--- vlog.f
design/isa_pkg.sv
design/fetch_bus_pkg.sv
design/fetch_cfg.sv
design/pc_gen.sv
design/imem_port.sv
design/if_stage.sv
design/fetch_top.sv
bench/fetch_checker.sv
bench/tb_fetch_top.sv
